// File: include/debug_unit_macros.svh
`ifndef DEBUG_UNIT_MACROS_SVH
`define DEBUG_UNIT_MACROS_SVH

// Sizes
`define DBG_N_STAGES        5
`define DBG_N_REGISTERS     32
`define DBG_REG_ADDR_BITS   5
`define DBG_DATA_BITS       32
`define DBG_BYTE_BITS       8
`define DBG_WORD_BYTES      4

// ASCII command bytes: E N R P C D L
`define DBG_CMD_RUN         8'h45
`define DBG_CMD_STEP        8'h4E
`define DBG_CMD_READ_REGS   8'h52
`define DBG_CMD_READ_PC     8'h50
`define DBG_CMD_RESET_PC    8'h43
`define DBG_CMD_FLUSH       8'h44
`define DBG_CMD_LOAD        8'h4C

// Terminator, only valid at the first byte of a word
`define DBG_PROG_END_MARKER 8'hF4

`endif

// File: design/debug_unit_pkg.sv
`default_nettype none

`include "debug_unit_macros.svh"

package debug_unit_pkg;

    typedef logic [`DBG_BYTE_BITS-1:0]     byte_t;
    typedef logic [`DBG_DATA_BITS-1:0]     word_t;
    typedef logic [`DBG_REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [`DBG_N_STAGES-1:0]      stage_enable_t;

    // Controller states
    typedef enum logic [3:0] {
        IDLE,
        RUN,
        STEP,
        DUMP_START,
        DUMP_SEND,
        DUMP_WAIT,
        DUMP_NEXT,
        READ_PC,
        RESET_PC,
        FLUSH,
        LOAD
    } dbg_state_t;

endpackage

`default_nettype wire

// File: design/debug_command_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_unit_macros.svh"

module debug_command_fsm (
    input  wire                            i_clock,
    input  wire                            i_reset,
    input  wire debug_unit_pkg::byte_t     i_rx_byte,
    input  wire                            i_rx_valid,
    input  wire                            i_tx_done,
    input  wire                            i_program_ended,
    input  wire                            i_program_loaded,
    input  wire                            i_dump_last,
    output debug_unit_pkg::stage_enable_t  o_stage_enable,
    output logic                           o_pc_reset,
    output logic                           o_delete_program,
    output logic                           o_dump_clear,
    output logic                           o_dump_advance,
    output logic                           o_load_active,
    output logic                           o_capture_pc,
    output logic                           o_capture_reg
);

    debug_unit_pkg::dbg_state_t    state;
    debug_unit_pkg::dbg_state_t    state_next;

    debug_unit_pkg::stage_enable_t stage_enable_next;
    logic                          pc_reset_next;
    logic                          delete_program_next;

    // --------------------------------------------------
    // State and pulse registers
    // --------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state            <= debug_unit_pkg::IDLE;
            o_stage_enable   <= '0;
            o_pc_reset       <= 1'b0;
            o_delete_program <= 1'b0;
        end else begin
            state            <= state_next;
            o_stage_enable   <= stage_enable_next;
            o_pc_reset       <= pc_reset_next;
            o_delete_program <= delete_program_next;
        end
    end

    // --------------------------------------------------
    // Next state and registered pulses
    // --------------------------------------------------
    always_comb begin
        state_next          = state;
        stage_enable_next   = '0;
        pc_reset_next       = 1'b0;
        delete_program_next = 1'b0;

        case (state)
            debug_unit_pkg::IDLE: begin
                // Unknown bytes keep us here
                if (i_rx_valid) begin
                    case (i_rx_byte)
                        `DBG_CMD_RUN:       state_next = debug_unit_pkg::RUN;
                        `DBG_CMD_STEP:      state_next = debug_unit_pkg::STEP;
                        `DBG_CMD_READ_REGS: state_next = debug_unit_pkg::DUMP_START;
                        `DBG_CMD_READ_PC:   state_next = debug_unit_pkg::READ_PC;
                        `DBG_CMD_RESET_PC:  state_next = debug_unit_pkg::RESET_PC;
                        `DBG_CMD_FLUSH:     state_next = debug_unit_pkg::FLUSH;
                        `DBG_CMD_LOAD:      state_next = debug_unit_pkg::LOAD;
                        default:            state_next = debug_unit_pkg::IDLE;
                    endcase
                end
            end

            debug_unit_pkg::RUN: begin
                if (i_program_ended) begin
                    state_next = debug_unit_pkg::IDLE;
                end else begin
                    stage_enable_next = '1;
                end
            end

            debug_unit_pkg::STEP: begin
                if (!i_program_ended) begin
                    stage_enable_next = '1;
                end
                state_next = debug_unit_pkg::IDLE;
            end

            // Register dump sequence
            debug_unit_pkg::DUMP_START: begin
                state_next = debug_unit_pkg::DUMP_SEND;
            end

            debug_unit_pkg::DUMP_SEND: begin
                state_next = debug_unit_pkg::DUMP_WAIT;
            end

            debug_unit_pkg::DUMP_WAIT: begin
                if (i_tx_done) begin
                    state_next = debug_unit_pkg::DUMP_NEXT;
                end
            end

            debug_unit_pkg::DUMP_NEXT: begin
                if (i_dump_last) begin
                    state_next = debug_unit_pkg::IDLE;
                end else begin
                    state_next = debug_unit_pkg::DUMP_SEND;
                end
            end

            debug_unit_pkg::READ_PC: begin
                state_next = debug_unit_pkg::IDLE;
            end

            debug_unit_pkg::RESET_PC: begin
                pc_reset_next = 1'b1;
                state_next    = debug_unit_pkg::IDLE;
            end

            debug_unit_pkg::FLUSH: begin
                pc_reset_next       = 1'b1;
                delete_program_next = 1'b1;
                state_next          = debug_unit_pkg::IDLE;
            end

            debug_unit_pkg::LOAD: begin
                // Loader raises the flag on the terminator
                if (i_program_loaded) begin
                    state_next = debug_unit_pkg::IDLE;
                end
            end

            default: begin
                state_next = debug_unit_pkg::IDLE;
            end
        endcase
    end

    // Strobes to the counter, loader and send register
    assign o_dump_clear   = (state == debug_unit_pkg::DUMP_START);
    assign o_capture_reg  = (state == debug_unit_pkg::DUMP_SEND);
    assign o_dump_advance = (state == debug_unit_pkg::DUMP_NEXT) && !i_dump_last;
    assign o_capture_pc   = (state == debug_unit_pkg::READ_PC);
    assign o_load_active  = (state == debug_unit_pkg::LOAD);

endmodule

`default_nettype wire

// File: design/register_dump_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_unit_macros.svh"

module register_dump_counter (
    input  wire                        i_clock,
    input  wire                        i_reset,
    input  wire                        i_clear,
    input  wire                        i_advance,
    output debug_unit_pkg::reg_addr_t  o_reg_address,
    output logic                       o_last
);

    localparam debug_unit_pkg::reg_addr_t LAST_INDEX =
        debug_unit_pkg::reg_addr_t'(`DBG_N_REGISTERS - 1);

    // --------------------------------------------------
    // Register index
    // --------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_reg_address <= '0;
        end else if (i_clear) begin
            o_reg_address <= '0;
        end else if (i_advance) begin
            o_reg_address <= o_reg_address + 1'b1;
        end
    end

    // Final register of the dump
    assign o_last = (o_reg_address == LAST_INDEX);

endmodule

`default_nettype wire

// File: design/program_loader.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_unit_macros.svh"

module program_loader (
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_load_active,
    input  wire                         i_flush,
    input  wire debug_unit_pkg::byte_t  i_rx_byte,
    input  wire                         i_rx_valid,
    output debug_unit_pkg::byte_t       o_prog_byte,
    output logic                        o_prog_write,
    output logic                        o_program_loaded
);

    localparam int SLOT_BITS = $clog2(`DBG_WORD_BYTES);

    logic [SLOT_BITS-1:0] slot;
    logic                 loaded;
    logic                 accept;
    logic                 end_marker;

    assign accept     = i_load_active && !loaded && i_rx_valid;
    assign end_marker = (i_rx_byte == `DBG_PROG_END_MARKER) && (slot == '0);

    // --------------------------------------------------
    // Slot counter and loaded flag
    // --------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            slot         <= '0;
            loaded       <= 1'b0;
            o_prog_write <= 1'b0;
        end else begin
            o_prog_write <= accept && !end_marker;
            if (!i_load_active) begin
                slot <= '0;
            end else if (accept && !end_marker) begin
                slot <= slot + 1'b1;
            end
            if (i_flush) begin
                loaded <= 1'b0;
            end else if (accept && end_marker) begin
                loaded <= 1'b1;
            end
        end
    end

    // Byte to instruction memory
    always_ff @(posedge i_clock) begin
        if (accept) begin
            o_prog_byte <= i_rx_byte;
        end
    end

    // Flush hides the flag in its own cycle
    assign o_program_loaded = loaded && !i_flush;

endmodule

`default_nettype wire

// File: design/uart_send_register.sv
`timescale 1ns/100ps
`default_nettype none

module uart_send_register (
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_capture_pc,
    input  wire                         i_capture_reg,
    input  wire debug_unit_pkg::word_t  i_pc,
    input  wire debug_unit_pkg::word_t  i_reg_data,
    output debug_unit_pkg::word_t       o_tx_data,
    output logic                        o_tx_start
);

    // --------------------------------------------------
    // Transmit word
    // --------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_capture_pc) begin
            o_tx_data <= i_pc;
        end else if (i_capture_reg) begin
            o_tx_data <= i_reg_data;
        end
    end

    // Start pulse one cycle after capture
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= i_capture_pc || i_capture_reg;
        end
    end

endmodule

`default_nettype wire

// File: design/debug_unit.sv
`timescale 1ns/100ps
`default_nettype none

module debug_unit (
    input  wire                                 i_clock,
    input  wire                                 i_reset,

    // UART side
    input  wire debug_unit_pkg::byte_t          i_rx_byte,
    input  wire                                 i_rx_valid,
    input  wire                                 i_tx_done,
    output wire debug_unit_pkg::word_t          o_tx_data,
    output wire                                 o_tx_start,

    // Processor side
    input  wire debug_unit_pkg::word_t          i_reg_data,
    input  wire debug_unit_pkg::word_t          i_pc,
    input  wire                                 i_program_ended,
    output wire debug_unit_pkg::reg_addr_t      o_reg_address,
    output wire debug_unit_pkg::stage_enable_t  o_stage_enable,
    output wire                                 o_pc_reset,
    output wire                                 o_delete_program,
    output wire debug_unit_pkg::byte_t          o_prog_byte,
    output wire                                 o_prog_write,
    output wire                                 o_program_loaded
);

    logic dump_clear;
    logic dump_advance;
    logic dump_last;
    logic load_active;
    logic capture_pc;
    logic capture_reg;

    // --------------------------------------------------
    // Command decoder
    // --------------------------------------------------
    debug_command_fsm u_command_fsm (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_rx_byte        (i_rx_byte),
        .i_rx_valid       (i_rx_valid),
        .i_tx_done        (i_tx_done),
        .i_program_ended  (i_program_ended),
        .i_program_loaded (o_program_loaded),
        .i_dump_last      (dump_last),
        .o_stage_enable   (o_stage_enable),
        .o_pc_reset       (o_pc_reset),
        .o_delete_program (o_delete_program),
        .o_dump_clear     (dump_clear),
        .o_dump_advance   (dump_advance),
        .o_load_active    (load_active),
        .o_capture_pc     (capture_pc),
        .o_capture_reg    (capture_reg)
    );

    register_dump_counter u_dump_counter (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_clear       (dump_clear),
        .i_advance     (dump_advance),
        .o_reg_address (o_reg_address),
        .o_last        (dump_last)
    );

    // Flush reuses the delete pulse
    program_loader u_program_loader (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_load_active    (load_active),
        .i_flush          (o_delete_program),
        .i_rx_byte        (i_rx_byte),
        .i_rx_valid       (i_rx_valid),
        .o_prog_byte      (o_prog_byte),
        .o_prog_write     (o_prog_write),
        .o_program_loaded (o_program_loaded)
    );

    uart_send_register u_send_register (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_capture_pc  (capture_pc),
        .i_capture_reg (capture_reg),
        .i_pc          (i_pc),
        .i_reg_data    (i_reg_data),
        .o_tx_data     (o_tx_data),
        .o_tx_start    (o_tx_start)
    );

endmodule

`default_nettype wire

// File: sim/tb_debug_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "debug_unit_macros.svh"

module tb_debug_unit;

    localparam int CLOCK_PERIOD = 20;
    // Worst case per dump word is 8 reply cycles plus turnaround
    // The other tests take about 200 cycles
    localparam int TEST_CYCLES  = `DBG_N_REGISTERS * 13 + 200;
    localparam int WATCHDOG_NS  = (TEST_CYCLES + 200) * CLOCK_PERIOD;
    localparam logic [31:0] STAGES_ON = (1 << `DBG_N_STAGES) - 1;
    localparam debug_unit_pkg::byte_t PROGRAM [9] =
        '{8'h11, 8'h22, 8'h33, 8'hF4, 8'h55, 8'hF4, 8'h66, 8'h77, 8'hF4};

    logic                          i_clock;
    logic                          i_reset;
    debug_unit_pkg::byte_t         i_rx_byte;
    logic                          i_rx_valid;
    logic                          i_tx_done;
    debug_unit_pkg::word_t         i_reg_data;
    debug_unit_pkg::word_t         i_pc;
    logic                          i_program_ended;
    debug_unit_pkg::word_t         o_tx_data;
    logic                          o_tx_start;
    debug_unit_pkg::reg_addr_t     o_reg_address;
    debug_unit_pkg::stage_enable_t o_stage_enable;
    logic                          o_pc_reset;
    logic                          o_delete_program;
    debug_unit_pkg::byte_t         o_prog_byte;
    logic                          o_prog_write;
    logic                          o_program_loaded;

    debug_unit_pkg::word_t tx_words[$];
    debug_unit_pkg::byte_t prog_writes[$];
    debug_unit_pkg::byte_t expected_writes[$];
    logic                  tx_busy;
    int                    load_slot;

    debug_unit u_dut (.*);

    // Register file model
    function automatic debug_unit_pkg::word_t reg_value(
        input debug_unit_pkg::reg_addr_t index
    );
        reg_value = 32'h1000_0003 + 32'h0001_0101 * 32'(index);
    endfunction

    assign i_reg_data = reg_value(o_reg_address);

    // --------------------------------------------------
    // Reporting
    // --------------------------------------------------
    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("[FAIL] %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    // --------------------------------------------------
    // Stimulus helpers, all entered on a falling edge
    // --------------------------------------------------
    task automatic idle(input int cycles);
        repeat (cycles) @(negedge i_clock);
    endtask

    task automatic send_byte(input debug_unit_pkg::byte_t value);
        i_rx_byte  = value;
        i_rx_valid = 1'b1;
        @(negedge i_clock);
        i_rx_valid = 1'b0;
    endtask

    // Terminator only counts at slot 0
    // Anything else is a data byte
    task automatic load_byte(input debug_unit_pkg::byte_t value);
        send_byte(value);
        if (value != `DBG_PROG_END_MARKER || load_slot != 0) begin
            expected_writes.push_back(value);
            load_slot = (load_slot + 1) % `DBG_WORD_BYTES;
        end
        idle(2);
    endtask

    task automatic compare_writes();
        check_value("o_prog_write count", expected_writes.size(), prog_writes.size());
        foreach (expected_writes[i]) begin
            check_value("o_prog_byte", 32'(expected_writes[i]), 32'(prog_writes[i]));
        end
        expected_writes.delete();
        prog_writes.delete();
    endtask

    task automatic wait_tx_idle(input int count);
        int cycles;
        cycles = 0;
        while (tx_words.size() != count || tx_busy) begin
            @(negedge i_clock);
            cycles++;
            if (cycles > 12 * count + 20) begin
                report_failure("transmitted words never reached the expected count");
            end
        end
    endtask

    // --------------------------------------------------
    // Clock, watchdog, monitors
    // --------------------------------------------------
    initial begin : clock_gen
        i_clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
    end

    always @(negedge i_clock) begin
        if (o_prog_write) begin
            prog_writes.push_back(o_prog_byte);
        end
    end

    // Transmitter answers each start after 1 to 8 cycles
    initial begin : transmitter_model
        int unsigned delay;
        void'($urandom(53072));
        i_tx_done = 1'b0;
        tx_busy   = 1'b0;
        forever begin
            @(negedge i_clock);
            if (o_tx_start) begin
                tx_words.push_back(o_tx_data);
                tx_busy = 1'b1;
                delay   = $urandom_range(8, 1);
                repeat (delay) begin
                    @(negedge i_clock);
                    assert (!o_tx_start) else report_failure("o_tx_start before i_tx_done");
                end
                i_tx_done = 1'b1;
                @(negedge i_clock);
                i_tx_done = 1'b0;
                tx_busy   = 1'b0;
                assert (!o_tx_start) else report_failure("o_tx_start before i_tx_done");
            end
        end
    end

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    initial begin : stimulus
        i_reset         = 1'b1;
        i_rx_byte       = '0;
        i_rx_valid      = 1'b0;
        i_pc            = 32'hCAFE_0124;
        i_program_ended = 1'b0;
        load_slot       = 0;
        repeat (2) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;
        check_value("o_stage_enable", 0, 32'(o_stage_enable));
        check_value("o_pc_reset", 0, 32'(o_pc_reset));
        check_value("o_delete_program", 0, 32'(o_delete_program));
        check_value("o_prog_write", 0, 32'(o_prog_write));
        check_value("o_tx_start", 0, 32'(o_tx_start));
        check_value("o_program_loaded", 0, 32'(o_program_loaded));

        // Load, then a second load that must be refused
        send_byte(`DBG_CMD_LOAD);
        foreach (PROGRAM[i]) begin
            load_byte(PROGRAM[i]);
        end
        check_value("o_program_loaded", 1, 32'(o_program_loaded));
        idle(2);
        compare_writes();
        send_byte(`DBG_CMD_LOAD);
        send_byte(8'h12);
        idle(2);
        send_byte(8'h34);
        idle(3);
        compare_writes();

        // Step, run, then step after the program ended
        send_byte(`DBG_CMD_STEP);
        check_value("o_stage_enable", 0, 32'(o_stage_enable));
        @(negedge i_clock);
        check_value("o_stage_enable", STAGES_ON, 32'(o_stage_enable));
        @(negedge i_clock);
        check_value("o_stage_enable", 0, 32'(o_stage_enable));
        send_byte(`DBG_CMD_RUN);
        check_value("o_stage_enable", 0, 32'(o_stage_enable));
        repeat (5) begin
            @(negedge i_clock);
            check_value("o_stage_enable", STAGES_ON, 32'(o_stage_enable));
        end
        i_program_ended = 1'b1;
        @(negedge i_clock);
        check_value("o_stage_enable", 0, 32'(o_stage_enable));
        idle(2);
        send_byte(`DBG_CMD_STEP);
        repeat (3) begin
            check_value("o_stage_enable", 0, 32'(o_stage_enable));
            @(negedge i_clock);
        end
        i_program_ended = 1'b0;

        // Register dump
        send_byte(`DBG_CMD_READ_REGS);
        wait_tx_idle(`DBG_N_REGISTERS);
        idle(4);
        check_value("o_tx_start count", `DBG_N_REGISTERS, tx_words.size());
        for (int k = 0; k < `DBG_N_REGISTERS; k++) begin
            check_value("o_tx_data", reg_value(debug_unit_pkg::reg_addr_t'(k)), tx_words[k]);
        end
        tx_words.delete();

        // PC commands
        send_byte(`DBG_CMD_READ_PC);
        @(negedge i_clock);
        check_value("o_tx_start", 1, 32'(o_tx_start));
        check_value("o_tx_data", i_pc, o_tx_data);
        wait_tx_idle(1);
        tx_words.delete();
        send_byte(`DBG_CMD_RESET_PC);
        @(negedge i_clock);
        check_value("o_pc_reset", 1, 32'(o_pc_reset));
        check_value("o_delete_program", 0, 32'(o_delete_program));
        @(negedge i_clock);
        check_value("o_pc_reset", 0, 32'(o_pc_reset));
        send_byte(`DBG_CMD_FLUSH);
        @(negedge i_clock);
        check_value("o_pc_reset", 1, 32'(o_pc_reset));
        check_value("o_delete_program", 1, 32'(o_delete_program));
        check_value("o_program_loaded", 0, 32'(o_program_loaded));
        @(negedge i_clock);
        check_value("o_pc_reset", 0, 32'(o_pc_reset));
        check_value("o_delete_program", 0, 32'(o_delete_program));
        check_value("o_program_loaded", 0, 32'(o_program_loaded));

        // Reload after flush
        send_byte(`DBG_CMD_LOAD);
        load_slot = 0;
        load_byte(8'hA1);
        load_byte(8'hB2);
        load_byte(8'hC3);
        load_byte(8'hD4);
        load_byte(`DBG_PROG_END_MARKER);
        check_value("o_program_loaded", 1, 32'(o_program_loaded));
        idle(2);
        compare_writes();

        idle(2);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
design/debug_unit_pkg.sv
design/debug_command_fsm.sv
design/register_dump_counter.sv
design/program_loader.sv
design/uart_send_register.sv
design/debug_unit.sv
sim/tb_debug_unit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Mdir obj_dir
TOP       = tb_debug_unit
FILELIST  = src.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
